// File: coreParamsPkg.sv
package coreParamsPkg;

  // instructions per group at dispatch, completion and retirement
  localparam int numSuper = 2;

  // reorder buffer
  localparam int numRob = 8;
  localparam int robIdxWidth = $clog2(numRob);

  // architectural register file
  localparam int numArchRegs = 8;
  localparam int archIdxWidth = $clog2(numArchRegs);

  // physical tags, the upper half starts out free
  localparam int numPhysRegs = 16;
  localparam int physIdxWidth = $clog2(numPhysRegs);

endpackage

// File: instrFormatPkg.sv
package instrFormatPkg;
  import coreParamsPkg::*;

  localparam int instrWidth = 16;
  localparam int opcodeWidth = 4;
  // unused low bits of the register format
  localparam int spareWidth = instrWidth - opcodeWidth - 3 * archIdxWidth;

  typedef enum logic [opcodeWidth-1:0] {
    opAdd    = 4'h0,
    opSub    = 4'h1,
    opBranch = 4'h2,
    opHalt   = 4'h3
  } opcodeT;

  // add and sub
  typedef struct packed {
    opcodeT                  opcode;
    logic [archIdxWidth-1:0] dest;
    logic [archIdxWidth-1:0] src0;
    logic [archIdxWidth-1:0] src1;
    logic [spareWidth-1:0]   spare;
  } regFormatT;

  // branch and halt, no destination register
  typedef struct packed {
    opcodeT                            opcode;
    logic [instrWidth-opcodeWidth-1:0] imm;
  } sysFormatT;

  // opcode sits in the top bits of both views
  typedef union packed {
    regFormatT regForm;
    sysFormatT sysForm;
  } instrWordT;

endpackage

// File: dispatchDecoder.sv
`timescale 1ns/100ps

module dispatchDecoder import coreParamsPkg::*, instrFormatPkg::*; (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    inReq,
  input  instrWordT               inWord0,
  input  instrWordT               inWord1,
  output logic                    inAck,
  output logic                    decValid,
  output logic [archIdxWidth-1:0] decDest0,
  output logic [archIdxWidth-1:0] decDest1,
  output logic                    decWrites0,
  output logic                    decWrites1,
  output logic                    decHalt0,
  output logic                    decHalt1,
  input  logic                    renAccept
);

  logic capture;

  // only the register format writes a destination
  function automatic logic writesReg(instrWordT word);
    return word.regForm.opcode inside {opAdd, opSub};
  endfunction

  function automatic logic isHalt(instrWordT word);
    return word.sysForm.opcode == opHalt;
  endfunction

  // fresh request, and the decode register is empty or drains this cycle
  assign capture = inReq && !inAck && (!decValid || renAccept);

  always_ff @(posedge clock) begin
    if (reset) begin
      inAck <= 1'b0;
      decValid <= 1'b0;
    end else begin
      if (capture) begin
        inAck <= 1'b1;
      end else if (!inReq) begin
        inAck <= 1'b0;
      end
      if (capture) begin
        decValid <= 1'b1;
      end else if (renAccept) begin
        decValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (capture) begin
      decDest0 <= inWord0.regForm.dest;
      decDest1 <= inWord1.regForm.dest;
      decWrites0 <= writesReg(inWord0);
      decWrites1 <= writesReg(inWord1);
      decHalt0 <= isHalt(inWord0);
      decHalt1 <= isHalt(inWord1);
    end
  end

  // acknowledge only answers a raised request
  assert property (@(posedge clock) disable iff (reset) !inReq && !inAck |=> !inAck);

  // sender keeps the request up until it is acknowledged
  assert property (@(posedge clock) disable iff (reset) inReq && !inAck |=> inReq);

endmodule

// File: renameStage.sv
`timescale 1ns/100ps

module renameStage import coreParamsPkg::*; (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic                                      decValid,
  input  logic [archIdxWidth-1:0]                   decDest0,
  input  logic [archIdxWidth-1:0]                   decDest1,
  input  logic                                      decWrites0,
  input  logic                                      decWrites1,
  input  logic                                      decHalt0,
  input  logic                                      decHalt1,
  output logic                                      renAccept,
  output logic                                      renValid,
  output logic [archIdxWidth-1:0]                   renDest0,
  output logic [archIdxWidth-1:0]                   renDest1,
  output logic                                      renWrites0,
  output logic                                      renWrites1,
  output logic                                      renHalt0,
  output logic                                      renHalt1,
  output logic [physIdxWidth-1:0]                   renTag0,
  output logic [physIdxWidth-1:0]                   renTag1,
  output logic [physIdxWidth-1:0]                   renTold0,
  output logic [physIdxWidth-1:0]                   renTold1,
  input  logic                                      robAccept,
  input  logic                                      freeEn0,
  input  logic                                      freeEn1,
  input  logic [physIdxWidth-1:0]                   freeTold0,
  input  logic [physIdxWidth-1:0]                   freeTold1,
  input  logic [numArchRegs-1:0][physIdxWidth-1:0] archImage,
  input  logic                                      rebuildReq
);

  logic [numArchRegs-1:0][physIdxWidth-1:0] mapTable;
  // one bit per tag, set when free
  logic [numPhysRegs-1:0] freeList;
  logic [numPhysRegs-1:0] rebuildFree;
  logic [numPhysRegs-1:0] mappedTags;
  logic [physIdxWidth-1:0] pick0;
  logic [physIdxWidth-1:0] pick1;
  logic [physIdxWidth-1:0] allocTag1;
  logic [physIdxWidth-1:0] oldTag1;
  logic found0;
  logic found1;
  logic fire;

  // two lowest free tags
  always_comb begin
    found0 = 1'b0;
    found1 = 1'b0;
    pick0 = '0;
    pick1 = '0;
    for (int t = 0; t < numPhysRegs; t++) begin
      if (freeList[t] && !found0) begin
        found0 = 1'b1;
        pick0 = physIdxWidth'(t);
      end else if (freeList[t] && !found1) begin
        found1 = 1'b1;
        pick1 = physIdxWidth'(t);
      end
    end
  end

  // a non-writing first slot leaves the lowest tag to the second
  assign allocTag1 = decWrites0 ? pick1 : pick0;
  // second slot sees the first slot's fresh mapping
  assign oldTag1 = (decWrites0 && decDest0 == decDest1) ? pick0 : mapTable[decDest1];

  assign renAccept = found0 && found1 && !rebuildReq && (!renValid || robAccept);
  assign fire = decValid && renAccept;

  // after a rebuild every tag the committed map does not name is free
  always_comb begin
    rebuildFree = '1;
    for (int r = 0; r < numArchRegs; r++) begin
      rebuildFree[archImage[r]] = 1'b0;
    end
  end

  // tags named by the speculative map
  always_comb begin
    mappedTags = '0;
    for (int r = 0; r < numArchRegs; r++) begin
      mappedTags[mapTable[r]] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < numArchRegs; r++) begin
        mapTable[r] <= physIdxWidth'(r);
      end
      freeList <= {{(numPhysRegs - numArchRegs){1'b1}}, {numArchRegs{1'b0}}};
      renValid <= 1'b0;
    end else if (rebuildReq) begin
      mapTable <= archImage;
      freeList <= rebuildFree;
      // held pair was renamed against the discarded speculative map
      renValid <= 1'b0;
    end else begin
      if (freeEn0) begin
        freeList[freeTold0] <= 1'b1;
      end
      if (freeEn1) begin
        freeList[freeTold1] <= 1'b1;
      end
      if (fire) begin
        if (decWrites0) begin
          mapTable[decDest0] <= pick0;
          freeList[pick0] <= 1'b0;
        end
        if (decWrites1) begin
          mapTable[decDest1] <= allocTag1;
          freeList[allocTag1] <= 1'b0;
        end
        renValid <= 1'b1;
      end else if (robAccept) begin
        renValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fire) begin
      renDest0 <= decDest0;
      renDest1 <= decDest1;
      renWrites0 <= decWrites0;
      renWrites1 <= decWrites1;
      renHalt0 <= decHalt0;
      renHalt1 <= decHalt1;
      renTag0 <= pick0;
      renTag1 <= allocTag1;
      renTold0 <= mapTable[decDest0];
      renTold1 <= oldTag1;
    end
  end

  // a tag the speculative map still names is never handed out again
  assert property (@(posedge clock) disable iff (reset)
    fire |-> !(decWrites0 && mappedTags[pick0]) && !(decWrites1 && mappedTags[allocTag1]));

  // retirement only hands back tags that are still busy
  assert property (@(posedge clock) disable iff (reset) freeEn0 |-> !freeList[freeTold0]);

endmodule

// File: reorderBuffer.sv
`timescale 1ns/100ps

module reorderBuffer import coreParamsPkg::*; (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    renValid,
  input  logic [archIdxWidth-1:0] renDest0,
  input  logic [archIdxWidth-1:0] renDest1,
  input  logic                    renWrites0,
  input  logic                    renWrites1,
  input  logic                    renHalt0,
  input  logic                    renHalt1,
  input  logic [physIdxWidth-1:0] renTag0,
  input  logic [physIdxWidth-1:0] renTag1,
  input  logic [physIdxWidth-1:0] renTold0,
  input  logic [physIdxWidth-1:0] renTold1,
  output logic                    robAccept,
  input  logic [numSuper-1:0]     completeEn,
  input  logic [robIdxWidth-1:0]  completeIdx0,
  input  logic [robIdxWidth-1:0]  completeIdx1,
  input  logic                    rollbackEn,
  input  logic [robIdxWidth-1:0]  rollbackIdx,
  output logic                    dispatchFire,
  output logic [robIdxWidth-1:0]  dispatchIdx0,
  output logic [robIdxWidth-1:0]  dispatchIdx1,
  output logic [numSuper-1:0]     retireEn,
  output logic [archIdxWidth-1:0] retireDest0,
  output logic [archIdxWidth-1:0] retireDest1,
  output logic [physIdxWidth-1:0] retireTag0,
  output logic [physIdxWidth-1:0] retireTag1,
  output logic [physIdxWidth-1:0] retireTold0,
  output logic [physIdxWidth-1:0] retireTold1,
  output logic                    retireWrites0,
  output logic                    retireWrites1,
  output logic                    haltOut,
  output logic                    rebuildReq
);

  logic [numRob-1:0] entryValid;
  logic [numRob-1:0] entryComplete;
  logic [numRob-1:0] entryHalt;
  logic [numRob-1:0] entryWrites;
  logic [numRob-1:0] flushMask;
  logic [archIdxWidth-1:0] entryDest [numRob];
  logic [physIdxWidth-1:0] entryTag [numRob];
  logic [physIdxWidth-1:0] entryTold [numRob];
  logic [robIdxWidth-1:0] entryOffset [numRob];
  logic [robIdxWidth-1:0] head;
  logic [robIdxWidth-1:0] tail;
  logic [robIdxWidth-1:0] headPlusOne;
  logic [robIdxWidth-1:0] branchIdx;
  logic [robIdxWidth-1:0] branchOffset;
  logic [robIdxWidth:0] count;
  logic [robIdxWidth:0] retireCount;
  logic stalled;
  logic mispredict;

  assign headPlusOne = head + 1'b1;
  assign mispredict = rollbackEn && entryValid[rollbackIdx];

  // age relative to the head decides which entries are younger than the branch
  assign branchOffset = rollbackIdx - head;
  always_comb begin
    for (int i = 0; i < numRob; i++) begin
      entryOffset[i] = robIdxWidth'(i) - head;
      flushMask[i] = entryValid[i] && (entryOffset[i] > branchOffset);
    end
  end

  // retire completed entries in order from the head
  assign retireEn[0] = entryValid[head] && entryComplete[head];
  // a mispredicted branch at the head keeps its successor from retiring
  assign retireEn[1] = retireEn[0] && entryValid[headPlusOne] && entryComplete[headPlusOne]
                       && !(mispredict && rollbackIdx == head);
  assign retireCount = (robIdxWidth + 1)'(retireEn[0]) + (robIdxWidth + 1)'(retireEn[1]);

  assign retireDest0 = entryDest[head];
  assign retireDest1 = entryDest[headPlusOne];
  assign retireTag0 = entryTag[head];
  assign retireTag1 = entryTag[headPlusOne];
  assign retireTold0 = entryTold[head];
  assign retireTold1 = entryTold[headPlusOne];
  assign retireWrites0 = entryWrites[head];
  assign retireWrites1 = entryWrites[headPlusOne];
  assign haltOut = (retireEn[0] && entryHalt[head]) || (retireEn[1] && entryHalt[headPlusOne]);

  // two slots free once this cycle's retirements leave
  assign robAccept = !stalled && !mispredict
                     && (count - retireCount <= (robIdxWidth + 1)'(numRob - numSuper));
  assign dispatchFire = renValid && robAccept;
  assign dispatchIdx0 = tail;
  assign dispatchIdx1 = tail + 1'b1;

  // stall ends once the branch has left the head
  assign rebuildReq = stalled && !entryValid[branchIdx];

  always_ff @(posedge clock) begin
    if (reset) begin
      entryValid <= '0;
      entryComplete <= '0;
      head <= '0;
      tail <= '0;
      count <= '0;
      stalled <= 1'b0;
    end else begin
      if (completeEn[0]) begin
        entryComplete[completeIdx0] <= 1'b1;
      end
      if (completeEn[1]) begin
        entryComplete[completeIdx1] <= 1'b1;
      end
      if (retireEn[0]) begin
        entryValid[head] <= 1'b0;
      end
      if (retireEn[1]) begin
        entryValid[headPlusOne] <= 1'b0;
      end
      head <= head + retireCount[robIdxWidth-1:0];
      count <= count - retireCount;
      // dispatch after retire so a freed head slot can be refilled
      if (dispatchFire) begin
        entryValid[dispatchIdx0] <= 1'b1;
        entryValid[dispatchIdx1] <= 1'b1;
        entryComplete[dispatchIdx0] <= 1'b0;
        entryComplete[dispatchIdx1] <= 1'b0;
        tail <= tail + robIdxWidth'(numSuper);
        count <= count + (robIdxWidth + 1)'(numSuper) - retireCount;
      end
      if (mispredict) begin
        entryValid <= entryValid & ~flushMask;
        if (retireEn[0]) begin
          entryValid[head] <= 1'b0;
        end
        if (retireEn[1]) begin
          entryValid[headPlusOne] <= 1'b0;
        end
        tail <= rollbackIdx + 1'b1;
        count <= {1'b0, branchOffset} + 1'b1 - retireCount;
        stalled <= 1'b1;
      end else if (rebuildReq) begin
        stalled <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (dispatchFire) begin
      entryDest[dispatchIdx0] <= renDest0;
      entryDest[dispatchIdx1] <= renDest1;
      entryTag[dispatchIdx0] <= renTag0;
      entryTag[dispatchIdx1] <= renTag1;
      entryTold[dispatchIdx0] <= renTold0;
      entryTold[dispatchIdx1] <= renTold1;
      entryWrites[dispatchIdx0] <= renWrites0;
      entryWrites[dispatchIdx1] <= renWrites1;
      entryHalt[dispatchIdx0] <= renHalt0;
      entryHalt[dispatchIdx1] <= renHalt1;
    end
    if (mispredict) begin
      branchIdx <= rollbackIdx;
    end
  end

  // the second slot never retires alone
  assert property (@(posedge clock) disable iff (reset) retireEn[1] |-> retireEn[0]);

  // rebuild starts from an empty buffer
  assert property (@(posedge clock) disable iff (reset) rebuildReq |-> count == '0);

endmodule

// File: archMapTable.sv
`timescale 1ns/100ps

module archMapTable import coreParamsPkg::*; (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic [numSuper-1:0]                       retireEn,
  input  logic [archIdxWidth-1:0]                   retireDest0,
  input  logic [archIdxWidth-1:0]                   retireDest1,
  input  logic [physIdxWidth-1:0]                   retireTag0,
  input  logic [physIdxWidth-1:0]                   retireTag1,
  input  logic                                      retireWrites0,
  input  logic                                      retireWrites1,
  output logic                                      freeEn0,
  output logic                                      freeEn1,
  output logic [physIdxWidth-1:0]                   freeTold0,
  output logic [physIdxWidth-1:0]                   freeTold1,
  output logic [numArchRegs-1:0][physIdxWidth-1:0] archImage,
  input  logic [physIdxWidth-1:0]                   retireTold0,
  input  logic [physIdxWidth-1:0]                   retireTold1
);

  logic commit0;
  logic commit1;

  assign commit0 = retireEn[0] && retireWrites0;
  assign commit1 = retireEn[1] && retireWrites1;

  // slot 1 is younger, so it is written last and wins on the same register
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < numArchRegs; r++) begin
        archImage[r] <= physIdxWidth'(r);
      end
    end else begin
      if (commit0) begin
        archImage[retireDest0] <= retireTag0;
      end
      if (commit1) begin
        archImage[retireDest1] <= retireTag1;
      end
    end
  end

  // displaced tags go back to the free list on the retiring edge
  assign freeEn0 = commit0;
  assign freeEn1 = commit1;
  assign freeTold0 = retireTold0;
  assign freeTold1 = retireTold1;

endmodule

// File: renameRetireTop.sv
`timescale 1ns/100ps

module renameRetireTop import coreParamsPkg::*, instrFormatPkg::*; (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    inReq,
  input  instrWordT               inWord0,
  input  instrWordT               inWord1,
  output logic                    inAck,
  input  logic [numSuper-1:0]     completeEn,
  input  logic [robIdxWidth-1:0]  completeIdx0,
  input  logic [robIdxWidth-1:0]  completeIdx1,
  input  logic                    rollbackEn,
  input  logic [robIdxWidth-1:0]  rollbackIdx,
  output logic                    dispatchFire,
  output logic [robIdxWidth-1:0]  dispatchIdx0,
  output logic [robIdxWidth-1:0]  dispatchIdx1,
  output logic [numSuper-1:0]     retireEn,
  output logic [archIdxWidth-1:0] retireDest0,
  output logic [archIdxWidth-1:0] retireDest1,
  output logic [physIdxWidth-1:0] retireTag0,
  output logic [physIdxWidth-1:0] retireTag1,
  output logic [physIdxWidth-1:0] retireTold0,
  output logic [physIdxWidth-1:0] retireTold1,
  output logic                    retireWrites0,
  output logic                    retireWrites1,
  output logic                    haltOut
);

  // decode to rename
  logic decValid;
  logic [archIdxWidth-1:0] decDest0;
  logic [archIdxWidth-1:0] decDest1;
  logic decWrites0;
  logic decWrites1;
  logic decHalt0;
  logic decHalt1;
  logic renAccept;

  // rename to ROB
  logic renValid;
  logic [archIdxWidth-1:0] renDest0;
  logic [archIdxWidth-1:0] renDest1;
  logic renWrites0;
  logic renWrites1;
  logic renHalt0;
  logic renHalt1;
  logic [physIdxWidth-1:0] renTag0;
  logic [physIdxWidth-1:0] renTag1;
  logic [physIdxWidth-1:0] renTold0;
  logic [physIdxWidth-1:0] renTold1;
  logic robAccept;

  // committed state back to rename
  logic freeEn0;
  logic freeEn1;
  logic [physIdxWidth-1:0] freeTold0;
  logic [physIdxWidth-1:0] freeTold1;
  logic [numArchRegs-1:0][physIdxWidth-1:0] archImage;
  logic rebuildReq;

  dispatchDecoder decoder (.*);

  renameStage rename (.*);

  reorderBuffer rob (.*);

  archMapTable archMap (.*);

endmodule

// File: tbRenameRetire.sv
`timescale 1ns/100ps

module tbRenameRetire import coreParamsPkg::*, instrFormatPkg::*; ();

  localparam int waitLimit = 300;
  localparam int immWidth = instrWidth - 4 - archIdxWidth;

  typedef struct packed {
    logic [archIdxWidth-1:0] dest;
    logic                    writes;
    logic                    halt;
    logic [robIdxWidth-1:0]  idx;
  } instrRecT;

  logic clock;
  logic reset;
  logic inReq;
  instrWordT inWord0;
  instrWordT inWord1;
  logic inAck;
  logic [numSuper-1:0] completeEn;
  logic [robIdxWidth-1:0] completeIdx0;
  logic [robIdxWidth-1:0] completeIdx1;
  logic rollbackEn;
  logic [robIdxWidth-1:0] rollbackIdx;
  logic dispatchFire;
  logic [robIdxWidth-1:0] dispatchIdx0;
  logic [robIdxWidth-1:0] dispatchIdx1;
  logic [numSuper-1:0] retireEn;
  logic [archIdxWidth-1:0] retireDest0;
  logic [archIdxWidth-1:0] retireDest1;
  logic [physIdxWidth-1:0] retireTag0;
  logic [physIdxWidth-1:0] retireTag1;
  logic [physIdxWidth-1:0] retireTold0;
  logic [physIdxWidth-1:0] retireTold1;
  logic retireWrites0;
  logic retireWrites1;
  logic haltOut;

  // reference model, acknowledged pairs wait in sentQueue until dispatch
  instrRecT sentQueue[$];
  instrRecT robQueue[$];
  logic [robIdxWidth-1:0] pendingIdx[$];
  logic [physIdxWidth-1:0] committedTag [numArchRegs];
  logic autoComplete;
  int failCount;
  int testCount;

  renameRetireTop DUT (.*);

  always #50 clock = ~clock;

  task automatic flagError(string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    failCount++;
  endtask

  task automatic reportTimeout(string what);
    $display("timed out at %0t while waiting for %s", $time, what);
    failCount++;
  endtask

  task automatic endTest(string name);
    testCount++;
    $display("test %0d (%s) finished, %0d failures so far", testCount, name, failCount);
  endtask

  // opcode in the top nibble, destination below it
  function automatic instrRecT decodeWord(logic [instrWidth-1:0] word);
    instrRecT rec;
    rec.dest = word[instrWidth-5 -: archIdxWidth];
    rec.writes = word[instrWidth-1 -: 4] == 4'h0 || word[instrWidth-1 -: 4] == 4'h1;
    rec.halt = word[instrWidth-1 -: 4] == 4'h3;
    rec.idx = '0;
    return rec;
  endfunction

  function automatic logic [instrWidth-1:0] makeWord(logic [3:0] opcode,
                                                     logic [archIdxWidth-1:0] dest);
    return {opcode, dest, immWidth'($urandom)};
  endfunction

  function automatic logic [instrWidth-1:0] randomWord();
    int pick;
    logic [3:0] opcode;
    pick = $urandom_range(7, 0);
    case (pick)
      0, 1, 2: opcode = opAdd;
      3, 4, 5: opcode = opSub;
      6: opcode = opBranch;
      default: opcode = opHalt;
    endcase
    return makeWord(opcode, archIdxWidth'($urandom));
  endfunction

  task automatic raiseRequest(logic [instrWidth-1:0] word0, logic [instrWidth-1:0] word1);
    @(posedge clock);
    inReq <= 1'b1;
    inWord0 <= word0;
    inWord1 <= word1;
  endtask

  task automatic awaitAck(logic level, int limit, output logic seen);
    seen = 1'b0;
    for (int i = 0; i < limit && !seen; i++) begin
      @(negedge clock);
      seen = inAck == level;
    end
  endtask

  // pair is captured, log it and finish the four-phase cycle
  task automatic completeRequest(logic [instrWidth-1:0] word0, logic [instrWidth-1:0] word1);
    logic seen;
    sentQueue.push_back(decodeWord(word0));
    sentQueue.push_back(decodeWord(word1));
    @(posedge clock);
    inReq <= 1'b0;
    awaitAck(1'b0, waitLimit, seen);
    if (!seen) begin
      reportTimeout("inAck to fall");
    end
  endtask

  task automatic sendPair(logic [instrWidth-1:0] word0, logic [instrWidth-1:0] word1);
    logic seen;
    raiseRequest(word0, word1);
    awaitAck(1'b1, waitLimit, seen);
    if (seen) begin
      completeRequest(word0, word1);
    end else begin
      reportTimeout("inAck to rise");
      @(posedge clock);
      inReq <= 1'b0;
    end
  endtask

  task automatic waitOccupancy(int target, string what);
    logic done;
    done = 1'b0;
    for (int i = 0; i < waitLimit && !done; i++) begin
      @(negedge clock);
      done = sentQueue.size() == 0 && robQueue.size() == target;
    end
    if (!done) begin
      reportTimeout(what);
    end
  endtask

  task automatic checkRetire(logic [archIdxWidth-1:0] dest, logic [physIdxWidth-1:0] tag,
                             logic [physIdxWidth-1:0] told, logic writes, inout logic halt);
    instrRecT rec;
    if (robQueue.size() == 0) begin
      flagError("retirement with no dispatched instruction outstanding");
      return;
    end
    rec = robQueue.pop_front();
    assert (writes == rec.writes && (!rec.writes || dest == rec.dest))
      else flagError("retired instruction out of program order");
    if (rec.writes) begin
      assert (told == committedTag[rec.dest])
        else flagError("retireTold differs from the last committed tag");
      for (int r = 0; r < numArchRegs; r++) begin
        assert (committedTag[r] != tag) else flagError("retired tag is already live");
      end
      committedTag[rec.dest] = tag;
    end
    halt = halt || rec.halt;
  endtask

  // everything younger than the branch leaves the model
  task automatic flushYounger(logic [robIdxWidth-1:0] branchIdx);
    int pos;
    instrRecT rec;
    pos = -1;
    foreach (robQueue[i]) begin
      if (robQueue[i].idx == branchIdx) begin
        pos = i;
      end
    end
    while (pos >= 0 && robQueue.size() > pos + 1) begin
      rec = robQueue.pop_back();
      for (int k = pendingIdx.size() - 1; k >= 0; k--) begin
        if (pendingIdx[k] == rec.idx) begin
          pendingIdx.delete(k);
        end
      end
    end
  endtask

  task automatic recordDispatch(logic [robIdxWidth-1:0] idx0, logic [robIdxWidth-1:0] idx1);
    instrRecT rec;
    if (sentQueue.size() < numSuper) begin
      flagError("dispatch of a pair that was never acknowledged");
      return;
    end
    rec = sentQueue.pop_front();
    rec.idx = idx0;
    robQueue.push_back(rec);
    pendingIdx.push_back(idx0);
    rec = sentQueue.pop_front();
    rec.idx = idx1;
    robQueue.push_back(rec);
    pendingIdx.push_back(idx1);
    assert (robQueue.size() <= numRob) else flagError("more instructions in flight than ROB slots");
  endtask

  // model update and random completion order, once per edge
  always @(posedge clock) begin
    logic expHalt;
    logic [numSuper-1:0] nextEn;
    logic [robIdxWidth-1:0] nextIdx [numSuper];
    int pos;
    if (!reset) begin
      expHalt = 1'b0;
      if (retireEn[0]) begin
        checkRetire(retireDest0, retireTag0, retireTold0, retireWrites0, expHalt);
      end
      if (retireEn[1]) begin
        checkRetire(retireDest1, retireTag1, retireTold1, retireWrites1, expHalt);
      end
      assert (haltOut == expHalt) else flagError("haltOut does not match the retiring pair");
      if (rollbackEn) begin
        flushYounger(rollbackIdx);
      end
      if (dispatchFire) begin
        recordDispatch(dispatchIdx0, dispatchIdx1);
      end
      nextEn = '0;
      for (int s = 0; s < numSuper; s++) begin
        nextIdx[s] = '0;
        if (autoComplete && pendingIdx.size() > 0 && $urandom_range(3, 0) != 0) begin
          pos = $urandom_range(pendingIdx.size() - 1, 0);
          nextIdx[s] = pendingIdx[pos];
          pendingIdx.delete(pos);
          nextEn[s] = 1'b1;
        end
      end
      completeEn <= nextEn;
      completeIdx0 <= nextIdx[0];
      completeIdx1 <= nextIdx[1];
    end
  end

  assert property (@(posedge clock) disable iff (reset) $rose(inAck) |-> inReq)
    else flagError("inAck rose without inReq");
  assert property (@(posedge clock) disable iff (reset) $fell(inAck) |-> !inReq)
    else flagError("inAck fell while inReq was high");
  assert property (@(posedge clock) disable iff (reset) retireEn[1] |-> retireEn[0])
    else flagError("second retire slot fired alone");
  assert property (@(posedge clock) disable iff (reset) haltOut |-> retireEn[0])
    else flagError("haltOut without a retirement");

  initial begin
    logic [instrWidth-1:0] word0;
    logic [instrWidth-1:0] word1;
    logic [robIdxWidth-1:0] branchIdx;
    logic seen;
    logic stalled;
    void'($urandom(6703));
    clock = 1'b0;
    reset = 1'b1;
    inReq = 1'b0;
    inWord0 = '0;
    inWord1 = '0;
    completeEn = '0;
    completeIdx0 = '0;
    completeIdx1 = '0;
    rollbackEn = 1'b0;
    rollbackIdx = '0;
    autoComplete = 1'b1;
    failCount = 0;
    testCount = 0;
    for (int r = 0; r < numArchRegs; r++) begin
      committedTag[r] = physIdxWidth'(r);
    end
    repeat (4) @(posedge clock);
    reset <= 1'b0;

    for (int p = 0; p < 4; p++) begin
      sendPair(randomWord(), randomWord());
    end
    waitOccupancy(0, "the ROB to drain");
    endTest("handshake");

    for (int p = 0; p < 16; p++) begin
      sendPair(randomWord(), randomWord());
    end
    waitOccupancy(0, "the ROB to drain");
    endTest("in-order retirement");

    // same destination in both slots, and a non-writer in slot 0
    for (int p = 0; p < 6; p++) begin
      if (p % 2 == 0) begin
        sendPair(makeWord(opAdd, archIdxWidth'(p)), makeWord(opSub, archIdxWidth'(p)));
      end else begin
        sendPair(makeWord(opBranch, '0), makeWord(opAdd, archIdxWidth'(p)));
      end
    end
    waitOccupancy(0, "the ROB to drain");
    endTest("rename consistency");

    autoComplete = 1'b0;
    stalled = 1'b0;
    for (int p = 0; p < 2 * numRob && !stalled; p++) begin
      word0 = makeWord(opAdd, archIdxWidth'($urandom));
      word1 = makeWord(opSub, archIdxWidth'($urandom));
      raiseRequest(word0, word1);
      awaitAck(1'b1, 20, seen);
      if (seen) begin
        completeRequest(word0, word1);
      end else begin
        stalled = 1'b1;
      end
    end
    assert (stalled) else flagError("inAck kept answering with no completions");
    autoComplete = 1'b1;
    awaitAck(1'b1, waitLimit, seen);
    if (seen) begin
      completeRequest(word0, word1);
    end else begin
      reportTimeout("dispatch to resume after completions");
    end
    waitOccupancy(0, "the ROB to drain");
    endTest("back-pressure");

    autoComplete = 1'b0;
    sendPair(makeWord(opAdd, 3'd1), makeWord(opBranch, '0));
    sendPair(makeWord(opAdd, 3'd2), makeWord(opAdd, 3'd1));
    sendPair(makeWord(opSub, 3'd3), makeWord(opAdd, 3'd2));
    waitOccupancy(6, "three pairs to dispatch");
    branchIdx = robQueue[1].idx;
    @(posedge clock);
    rollbackEn <= 1'b1;
    rollbackIdx <= branchIdx;
    @(posedge clock);
    rollbackEn <= 1'b0;
    autoComplete = 1'b1;
    waitOccupancy(0, "the branch to retire");
    for (int p = 0; p < 4; p++) begin
      sendPair(randomWord(), randomWord());
    end
    waitOccupancy(0, "the ROB to drain");
    endTest("rollback");

    sendPair(makeWord(opHalt, '0), makeWord(opAdd, 3'd4));
    sendPair(makeWord(opAdd, 3'd5), makeWord(opHalt, '0));
    sendPair(makeWord(opHalt, '0), makeWord(opHalt, '0));
    waitOccupancy(0, "the ROB to drain");
    endTest("halt");

    $display("%0d tests finished with %0d failures", testCount, failCount);
    if (failCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: filelist.f
coreParamsPkg.sv
instrFormatPkg.sv
dispatchDecoder.sv
renameStage.sv
reorderBuffer.sv
archMapTable.sv
renameRetireTop.sv
tbRenameRetire.sv

// File: Bender.yml
package:
  name: rename_retire

sources:
  - target: any(rtl, test)
    files:
      - coreParamsPkg.sv
      - instrFormatPkg.sv
      - dispatchDecoder.sv
      - renameStage.sv
      - reorderBuffer.sv
      - archMapTable.sv
      - renameRetireTop.sv
  - target: test
    files:
      - tbRenameRetire.sv
